/* hdl/rp_pkg.sv */
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////
  // adc samples
  ////////////////////////////////////////

  localparam int unsigned ADC_DW = 14;

  typedef logic        [ADC_DW-1:0] adc_raw_t;  // offset binary, negative slope
  typedef logic signed [ADC_DW-1:0] adc_smp_t;  // two's complement

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  localparam int unsigned SYS_AW = 32;
  localparam int unsigned SYS_DW = 32;
  localparam int unsigned SYS_SW = 20;  // offset bits per region

  typedef logic [SYS_AW-1:0] sys_addr_t;
  typedef logic [SYS_DW-1:0] sys_data_t;

  // address bits 22:20
  typedef enum logic [2:0] {
    REG_HK       = 3'd0,
    REG_SCOPE_01 = 3'd1,  // unmapped from here on, except ams
    REG_SCOPE_23 = 3'd2,
    REG_ASG      = 3'd3,
    REG_AMS      = 3'd4,
    REG_DAISY    = 3'd5,
    REG_SPARE_6  = 3'd6,
    REG_SPARE_7  = 3'd7
  } sys_region_e;

  // housekeeping offsets
  typedef enum logic [SYS_SW-1:0] {
    HK_ID      = 20'h00,  // read only
    HK_EXP_DIR = 20'h10,
    HK_EXP_OUT = 20'h18,
    HK_EXP_IN  = 20'h20,  // read only, live pins
    HK_LED     = 20'h30
  } hk_reg_e;

  // pdm setting offsets
  typedef enum logic [SYS_SW-1:0] {
    AMS_PDM_A = 20'h20,
    AMS_PDM_B = 20'h24,
    AMS_PDM_C = 20'h28,
    AMS_PDM_D = 20'h2C
  } ams_reg_e;

  ////////////////////////////////////////
  // misc
  ////////////////////////////////////////

  typedef logic [7:0] pdm_cfg_t;

  localparam int unsigned PDM_RNG     = 255;
  localparam sys_data_t   HK_ID_VALUE = 32'h5250_0001;
  localparam int unsigned LED_W       = 8;

endpackage

`default_nettype wire

/* hdl/rp_adc_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_adc_frontend import rp_pkg::*; #(
  parameter int unsigned NCH = 4
) (
  input  wire logic               adc_clk_01,
  input  wire logic               reset_i,
  input  adc_raw_t [NCH-1:0]      adc_raw_i,  // captured words, one per channel
  output adc_smp_t [NCH-1:0]      adc_dat_o
);

  adc_smp_t [NCH-1:0] conv_q;  // stage 1, converted
  adc_smp_t [NCH-1:0] dat_q;   // stage 2, retimed

  ////////////////////////////////////////
  // conversion stage
  ////////////////////////////////////////

  // msb kept, rest inverted
  // neg slope offset binary -> two's complement
  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      conv_q <= '0;
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        conv_q[ch] <= {adc_raw_i[ch][ADC_DW-1], ~adc_raw_i[ch][ADC_DW-2:0]};
      end
    end
  end

  ////////////////////////////////////////
  // retiming stage
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      dat_q <= '0;
    end else begin
      dat_q <= conv_q;  // second register, 2 cycles total
    end
  end

  assign adc_dat_o = dat_q;

endmodule

`default_nettype wire

/* hdl/rp_sys_bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_sys_bus_decoder import rp_pkg::*; (
  input  wire logic              adc_clk_01,
  input  wire logic              reset_i,
  // master side
  input  sys_addr_t              sys_addr_i,
  input  sys_data_t              sys_wdata_i,
  input  wire logic              sys_wen_i,
  input  wire logic              sys_ren_i,
  output sys_data_t              sys_rdata_o,
  output logic                   sys_ack_o,
  output logic                   sys_err_o,
  // shared target request
  output logic [SYS_SW-1:0]      tgt_addr_o,
  output sys_data_t              tgt_wdata_o,
  output logic                   hk_wen_o,
  output logic                   hk_ren_o,
  output logic                   ams_wen_o,
  output logic                   ams_ren_o,
  // target responses
  input  sys_data_t              hk_rdata_i,
  input  wire logic              hk_ack_i,
  input  wire logic              hk_err_i,
  input  sys_data_t              ams_rdata_i,
  input  wire logic              ams_ack_i,
  input  wire logic              ams_err_i
);

  sys_region_e region;    // region of current request
  sys_region_e region_q;  // region of request in flight
  logic        req;
  logic        unm_ack_q; // own answer for unmapped regions

  assign region = sys_region_e'(sys_addr_i[SYS_SW+2:SYS_SW]);
  assign req    = sys_wen_i | sys_ren_i;

  // steer pulse, offset and data to the targets
  assign tgt_addr_o  = sys_addr_i[SYS_SW-1:0];
  assign tgt_wdata_o = sys_wdata_i;
  assign hk_wen_o    = sys_wen_i && (region == REG_HK);
  assign hk_ren_o    = sys_ren_i && (region == REG_HK);
  assign ams_wen_o   = sys_wen_i && (region == REG_AMS);
  assign ams_ren_o   = sys_ren_i && (region == REG_AMS);

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      region_q  <= REG_HK;
      unm_ack_q <= 1'b0;
    end else begin
      if (req) region_q <= region;  // held until next request
      unm_ack_q <= req && (region != REG_HK) && (region != REG_AMS);
    end
  end

  ////////////////////////////////////////
  // response multiplexer
  ////////////////////////////////////////

  always_comb begin
    case (region_q)
      REG_HK: begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
        sys_err_o   = hk_err_i;
      end
      REG_AMS: begin
        sys_rdata_o = ams_rdata_i;
        sys_ack_o   = ams_ack_i;
        sys_err_o   = ams_err_i;
      end
      default: begin  // nothing behind it
        sys_rdata_o = '0;
        sys_ack_o   = unm_ack_q;
        sys_err_o   = unm_ack_q;
      end
    endcase
  end

  // every answer traces back to a request one cycle before
  a_ack_after_req: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    sys_ack_o |-> $past(req));

endmodule

`default_nettype wire

/* hdl/rp_hk.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_hk import rp_pkg::*; #(
  parameter int unsigned DWE = 11
) (
  input  wire logic              adc_clk_01,
  input  wire logic              reset_i,
  // bus
  input  wire logic [SYS_SW-1:0] addr_i,
  input  sys_data_t              wdata_i,
  input  wire logic              wen_i,
  input  wire logic              ren_i,
  output sys_data_t              rdata_o,
  output logic                   ack_o,
  output logic                   err_o,
  // board pins
  output logic [LED_W-1:0]       led_o,
  output logic [DWE-1:0]         exp_p_o,
  output logic [DWE-1:0]         exp_p_dir_o,  // 1 = drive
  input  wire logic [DWE-1:0]    exp_p_i
);

  logic [LED_W-1:0] led_q;
  logic [DWE-1:0]   exp_out_q;
  logic [DWE-1:0]   exp_dir_q;
  logic             ack_q;
  logic             err_q;
  sys_data_t        rdata_q;
  sys_data_t        rd_data;  // decoded read value
  logic             rd_ok;
  logic             wr_ok;

  ////////////////////////////////////////
  // offset decode
  ////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    case (hk_reg_e'(addr_i))
      HK_ID:      rd_data = HK_ID_VALUE;
      HK_EXP_DIR: rd_data = sys_data_t'(exp_dir_q);
      HK_EXP_OUT: rd_data = sys_data_t'(exp_out_q);
      HK_EXP_IN:  rd_data = sys_data_t'(exp_p_i);  // live pins
      HK_LED:     rd_data = sys_data_t'(led_q);
      default:    rd_ok   = 1'b0;
    endcase
  end

  // only three writable offsets
  assign wr_ok = (addr_i == HK_EXP_DIR) || (addr_i == HK_EXP_OUT) || (addr_i == HK_LED);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      led_q     <= '0;  // leds off
      exp_out_q <= '0;
      exp_dir_q <= '0;  // all inputs
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ack_q <= wen_i | ren_i;
      err_q <= (wen_i & ~wr_ok) | (ren_i & ~rd_ok);
      if (wen_i) begin
        case (hk_reg_e'(addr_i))
          HK_EXP_DIR: exp_dir_q <= wdata_i[DWE-1:0];
          HK_EXP_OUT: exp_out_q <= wdata_i[DWE-1:0];
          HK_LED:     led_q     <= wdata_i[LED_W-1:0];
          default: ;  // read only or unknown, flagged above
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (ren_i) rdata_q <= rd_data;
  end

  assign rdata_o     = rdata_q;
  assign ack_o       = ack_q;
  assign err_o       = err_q;
  assign led_o       = led_q;
  assign exp_p_o     = exp_out_q;
  assign exp_p_dir_o = exp_dir_q;

  // decoder only ever forwards one kind of pulse
  a_no_wr_rd: assert property (@(posedge adc_clk_01) disable iff (reset_i)
    !(wen_i && ren_i));

endmodule

`default_nettype wire

/* hdl/rp_ams.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_ams import rp_pkg::*; (
  input  wire logic              adc_clk_01,
  input  wire logic              reset_i,
  // bus
  input  wire logic [SYS_SW-1:0] addr_i,
  input  sys_data_t              wdata_i,
  input  wire logic              wen_i,
  input  wire logic              ren_i,
  output sys_data_t              rdata_o,
  output logic                   ack_o,
  output logic                   err_o,
  // pdm settings, a..d
  output pdm_cfg_t [3:0]         pdm_cfg_o
);

  pdm_cfg_t [3:0] cfg_q;
  logic           ack_q;
  logic           err_q;
  sys_data_t      rdata_q;
  logic           hit;     // offset is one of the four

  assign hit = (addr_i == AMS_PDM_A) || (addr_i == AMS_PDM_B) ||
               (addr_i == AMS_PDM_C) || (addr_i == AMS_PDM_D);

  always_ff @(posedge adc_clk_01) begin
    if (reset_i) begin
      cfg_q <= '0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= wen_i | ren_i;
      err_q <= (wen_i | ren_i) & ~hit;
      if (wen_i) begin
        case (ams_reg_e'(addr_i))
          AMS_PDM_A: cfg_q[0] <= wdata_i[7:0];  // low byte only
          AMS_PDM_B: cfg_q[1] <= wdata_i[7:0];
          AMS_PDM_C: cfg_q[2] <= wdata_i[7:0];
          AMS_PDM_D: cfg_q[3] <= wdata_i[7:0];
          default: ;
        endcase
      end
    end
  end

  // readback zero extended, unknown reads zero
  always_ff @(posedge adc_clk_01) begin
    if (ren_i) begin
      rdata_q <= hit ? sys_data_t'(cfg_q[addr_i[3:2]]) : '0;
    end
  end

  assign rdata_o   = rdata_q;
  assign ack_o     = ack_q;
  assign err_o     = err_q;
  assign pdm_cfg_o = cfg_q;

endmodule

`default_nettype wire

/* hdl/rp_pdm.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_pdm import rp_pkg::*; (
  input  wire logic      adc_clk_01,
  input  wire logic      reset_i,
  input  pdm_cfg_t [3:0] pdm_cfg_i,
  output logic [3:0]     dac_pwm_o
);

  localparam logic [8:0] RNG = 9'(PDM_RNG);

  ////////////////////////////////////////
  // one accumulator per channel
  ////////////////////////////////////////

  for (genvar ch = 0; ch < 4; ch++) begin : g_ch
    logic [7:0] acc_q;  // always below range
    logic [8:0] sum;    // needs carry, up to 254 + 255
    logic       pdm_q;

    assign sum = {1'b0, acc_q} + {1'b0, pdm_cfg_i[ch]};

    always_ff @(posedge adc_clk_01) begin
      if (reset_i) begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end else if (sum >= RNG) begin
        acc_q <= 8'(sum - RNG);  // wrap, emit a one
        pdm_q <= 1'b1;
      end else begin
        acc_q <= sum[7:0];
        pdm_q <= 1'b0;
      end
    end

    assign dac_pwm_o[ch] = pdm_q;

    // modulo rule keeps the count exact over any 255 cycles
    a_acc_range: assert property (@(posedge adc_clk_01) disable iff (reset_i)
      acc_q < RNG[7:0]);
  end

endmodule

`default_nettype wire

/* hdl/rp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rp_top import rp_pkg::*; #(
  parameter int unsigned NCH = 4,   // adc channels
  parameter int unsigned DWE = 11   // expansion connector width
) (
  input  wire logic           adc_clk_01,
  input  wire logic           reset_i,
  // adc
  input  adc_raw_t [NCH-1:0]  adc_raw_i,
  output adc_smp_t [NCH-1:0]  adc_dat_o,
  // system bus
  input  sys_addr_t           sys_addr_i,
  input  sys_data_t           sys_wdata_i,
  input  wire logic           sys_wen_i,
  input  wire logic           sys_ren_i,
  output sys_data_t           sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  // board
  output logic [LED_W-1:0]    led_o,
  output logic [DWE-1:0]      exp_p_o,
  output logic [DWE-1:0]      exp_p_dir_o,
  input  wire logic [DWE-1:0] exp_p_i,
  output logic [3:0]          dac_pwm_o
);

  logic [SYS_SW-1:0] tgt_addr;
  sys_data_t         tgt_wdata;
  logic              hk_wen, hk_ren, hk_ack, hk_err;
  logic              ams_wen, ams_ren, ams_ack, ams_err;
  sys_data_t         hk_rdata, ams_rdata;
  pdm_cfg_t [3:0]    pdm_cfg;

  ////////////////////////////////////////
  // adc path
  ////////////////////////////////////////

  rp_adc_frontend #(.NCH(NCH)) u_adc (
    .adc_clk_01 (adc_clk_01), .reset_i (reset_i),
    .adc_raw_i  (adc_raw_i),  .adc_dat_o (adc_dat_o)
  );

  ////////////////////////////////////////
  // bus and register blocks
  ////////////////////////////////////////

  rp_sys_bus_decoder u_dec (
    .adc_clk_01  (adc_clk_01),  .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),  .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),   .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .tgt_addr_o  (tgt_addr),    .tgt_wdata_o (tgt_wdata),
    .hk_wen_o    (hk_wen),      .hk_ren_o    (hk_ren),
    .ams_wen_o   (ams_wen),     .ams_ren_o   (ams_ren),
    .hk_rdata_i  (hk_rdata),    .hk_ack_i    (hk_ack),    .hk_err_i  (hk_err),
    .ams_rdata_i (ams_rdata),   .ams_ack_i   (ams_ack),   .ams_err_i (ams_err)
  );

  rp_hk #(.DWE(DWE)) u_hk (
    .adc_clk_01 (adc_clk_01), .reset_i (reset_i),
    .addr_i     (tgt_addr),   .wdata_i (tgt_wdata),
    .wen_i      (hk_wen),     .ren_i   (hk_ren),
    .rdata_o    (hk_rdata),   .ack_o   (hk_ack),   .err_o (hk_err),
    .led_o      (led_o),
    .exp_p_o    (exp_p_o),    .exp_p_dir_o (exp_p_dir_o),
    .exp_p_i    (exp_p_i)
  );

  rp_ams u_ams (
    .adc_clk_01 (adc_clk_01), .reset_i (reset_i),
    .addr_i     (tgt_addr),   .wdata_i (tgt_wdata),
    .wen_i      (ams_wen),    .ren_i   (ams_ren),
    .rdata_o    (ams_rdata),  .ack_o   (ams_ack),  .err_o (ams_err),
    .pdm_cfg_o  (pdm_cfg)
  );

  ////////////////////////////////////////
  // pdm outputs
  ////////////////////////////////////////

  rp_pdm u_pdm (
    .adc_clk_01 (adc_clk_01), .reset_i   (reset_i),
    .pdm_cfg_i  (pdm_cfg),    .dac_pwm_o (dac_pwm_o)
  );

endmodule

`default_nettype wire

/* sim/tb_rp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rp_top import rp_pkg::*; ();

  localparam int unsigned NCH         = 4;
  localparam int unsigned DWE         = 11;
  localparam int unsigned ACK_TIMEOUT = 8;  // cycles
  localparam string       GOLDEN      = "sim/rp_golden.txt";

  logic               adc_clk_01;
  logic               reset_i;
  adc_raw_t [NCH-1:0] adc_raw;
  adc_smp_t [NCH-1:0] adc_dat;
  sys_addr_t          sys_addr;
  sys_data_t          sys_wdata;
  sys_data_t          sys_rdata;
  logic               sys_wen;
  logic               sys_ren;
  logic               sys_ack;
  logic               sys_err;
  logic [LED_W-1:0]   led;
  logic [DWE-1:0]     exp_out;
  logic [DWE-1:0]     exp_dir;
  logic [DWE-1:0]     exp_in;
  logic [3:0]         dac_pwm;
  int unsigned        n_checks;  // compares driven by the golden file

  rp_top u_dut (
    .adc_clk_01 (adc_clk_01), .reset_i (reset_i),
    .adc_raw_i (adc_raw), .adc_dat_o (adc_dat),
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata),
    .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .led_o (led), .exp_p_o (exp_out), .exp_p_dir_o (exp_dir), .exp_p_i (exp_in),
    .dac_pwm_o (dac_pwm)
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #20 adc_clk_01 = ~adc_clk_01;  // 40 ns period
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_smp(input adc_smp_t got, input adc_smp_t exp_v, input string what);
    n_checks++;
    if (got !== exp_v) begin
      $display("[FAIL] t=%0d ns %s: got %h, expected %h", $time, what, got, exp_v);
      abort_run();
    end
  endtask

  task automatic check_data(input sys_data_t got, input sys_data_t exp_v, input string what);
    n_checks++;
    if (got !== exp_v) begin
      $display("[FAIL] t=%0d ns %s: got %h, expected %h", $time, what, got, exp_v);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp_v, input string what);
    n_checks++;
    if (got !== exp_v) begin
      $display("[FAIL] t=%0d ns %s: got %b, expected %b", $time, what, got, exp_v);
      abort_run();
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp_v,
                             input string what);
    n_checks++;
    if (got != exp_v) begin
      $display("[FAIL] t=%0d ns %s: got %0d, expected %0d", $time, what, got, exp_v);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus tasks, entered on a falling edge
  ////////////////////////////////////////

  // random idle, no answer may show up meanwhile
  task automatic idle_gap();
    int unsigned gap;
    gap = 1 + ($urandom % 4);
    repeat (gap) begin
      @(posedge adc_clk_01);
      @(negedge adc_clk_01);
      check_flag(sys_ack, 1'b0, "ack_o while idle");
      check_flag(sys_err, 1'b0, "err_o while idle");
    end
  endtask

  task automatic bus_access(input logic is_wr, input sys_addr_t addr, input sys_data_t wdata,
                            input sys_data_t exp_rdata, input logic exp_err);
    int unsigned waited;
    string       what;
    what      = $sformatf("%s 0x%08h", is_wr ? "write" : "read", addr);
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = is_wr;
    sys_ren   = !is_wr;
    @(posedge adc_clk_01);  // pulse taken here
    @(negedge adc_clk_01);
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    waited  = 1;
    while (sys_ack !== 1'b1) begin
      if (waited >= ACK_TIMEOUT) begin
        $display("timeout: no ack within %0d cycles after %s", ACK_TIMEOUT, what);
        abort_run();
      end
      @(posedge adc_clk_01);
      @(negedge adc_clk_01);
      waited++;
    end
    check_count(waited, 1, $sformatf("%s ack latency", what));
    check_flag(sys_err, exp_err, $sformatf("%s err", what));
    if (!is_wr) check_data(sys_rdata, exp_rdata, $sformatf("%s rdata", what));
    idle_gap();
  endtask

  // word lives one cycle, its inverse right behind it
  task automatic drive_adc(input adc_raw_t [NCH-1:0] raw, input adc_smp_t [NCH-1:0] exp_smp);
    adc_raw = raw;
    @(posedge adc_clk_01);
    @(negedge adc_clk_01);
    adc_raw = ~raw;
    @(posedge adc_clk_01);
    @(negedge adc_clk_01);  // 2 cycles after the sample edge
    for (int ch = 0; ch < NCH; ch++) begin
      check_smp(adc_dat[ch[1:0]], exp_smp[ch[1:0]], $sformatf("adc_dat_o ch%0d", ch));
    end
    @(posedge adc_clk_01);
    @(negedge adc_clk_01);
    for (int ch = 0; ch < NCH; ch++) begin  // inverted input gives inverted sample
      check_smp(adc_dat[ch[1:0]], adc_smp_t'(~exp_smp[ch[1:0]]),
                $sformatf("adc_dat_o ch%0d next word", ch));
    end
  endtask

  task automatic check_pins(input logic [LED_W-1:0] exp_led, input logic [DWE-1:0] exp_o,
                            input logic [DWE-1:0] exp_d);
    check_data(sys_data_t'(led), sys_data_t'(exp_led), "led_o");
    check_data(sys_data_t'(exp_out), sys_data_t'(exp_o), "exp_p_o");
    check_data(sys_data_t'(exp_dir), sys_data_t'(exp_d), "exp_p_dir_o");
  endtask

  task automatic count_pdm(input logic [1:0] ch, input int unsigned exp_highs);
    int unsigned highs;
    highs = 0;
    for (int unsigned i = 0; i < PDM_RNG; i++) begin
      @(posedge adc_clk_01);
      @(negedge adc_clk_01);
      if (dac_pwm[ch]) highs++;
    end
    check_count(highs, exp_highs, $sformatf("dac_pwm_o[%0d] highs per window", ch));
  endtask

  task automatic expect_fields(input int got, input int want, input int lineno);
    if (got != want) begin
      $display("golden file line %0d holds %0d fields instead of %0d", lineno, got, want);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    string              line;
    logic [7:0]         cmd;
    logic [31:0]        f [8];
    adc_raw_t [NCH-1:0] raw_v;
    adc_smp_t [NCH-1:0] smp_v;
    int                 fd;
    int                 n;
    int                 lineno;

    adc_raw   = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    exp_in    = '0;
    reset_i   = 1'b1;
    n_checks  = 0;
    lineno    = 0;
    void'($urandom(16));  // idle gaps only

    repeat (2) @(posedge adc_clk_01);
    @(negedge adc_clk_01);
    reset_i = 1'b0;
    check_data(sys_data_t'(dac_pwm), '0, "dac_pwm_o after reset");
    idle_gap();

    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      $display("cannot open %s for reading", GOLDEN);
      abort_run();
    end

    n_checks = 0;  // from here on only golden lines count
    while ($fgets(line, fd) != 0) begin
      lineno++;
      if (line.len() > 1 && line.getc(0) != "#") begin
        cmd  = line.getc(0);
        line = line.substr(1, line.len() - 1);
        case (cmd)
          "A": begin  // raw words, expected samples
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            expect_fields(n, 8, lineno);
            raw_v = {f[3][13:0], f[2][13:0], f[1][13:0], f[0][13:0]};
            smp_v = {f[7][13:0], f[6][13:0], f[5][13:0], f[4][13:0]};
            drive_adc(raw_v, smp_v);
          end
          "W", "R": begin
            n = $sscanf(line, "%h %h %h", f[0], f[1], f[2]);
            expect_fields(n, 3, lineno);
            bus_access(cmd == "W", f[0], f[1], f[1], f[2][0]);
          end
          "X": begin
            n = $sscanf(line, "%h", f[0]);
            expect_fields(n, 1, lineno);
            exp_in = f[0][DWE-1:0];
          end
          "O": begin
            n = $sscanf(line, "%h %h %h", f[0], f[1], f[2]);
            expect_fields(n, 3, lineno);
            check_pins(f[0][LED_W-1:0], f[1][DWE-1:0], f[2][DWE-1:0]);
          end
          "P": begin
            n = $sscanf(line, "%d %d", f[0], f[1]);
            expect_fields(n, 2, lineno);
            count_pdm(f[0][1:0], f[1]);
          end
          default: begin
            $display("golden file line %0d has an unknown command", lineno);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);

    if (n_checks > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("golden file led to no checks");
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* sim/rp_golden.txt */
# A: raw ch0..ch3 then expected ch0..ch3 | W: addr wdata err | R: addr rdata err (all hex)
# X: exp_p_i (hex) | O: led exp_p_o exp_p_dir_o (hex) | P: channel highs per 255 cycles (dec)
O 00 000 000
A 0000 1fff 2000 3fff 1fff 0000 3fff 2000
A 0123 2abc 1555 3000 1edc 3543 0aaa 2fff
A 3fff 0000 1fff 2000 2000 1fff 0000 3fff
R 00000000 52500001 0
W 00000030 000000a5 0
O a5 000 000
R 00000030 000000a5 0
W 00000018 00000555 0
W 00000010 000007f0 0
O a5 555 7f0
R 00000018 00000555 0
R 00000010 000007f0 0
X 2aa
R 00000020 000002aa 0
X 155
R 00000020 00000155 0
W 00000000 12345678 1
R 00000000 52500001 0
W 00000020 000003ff 1
R 00000020 00000155 0
W 00000044 00000001 1
R 00000044 00000000 1
W 00100000 00000001 1
R 00500010 00000000 1
R 00700000 00000000 1
W 00400020 00000000 0
W 00400024 00000101 0
W 00400028 00000080 0
W 0040002c 000000fe 0
R 00400020 00000000 0
R 00400024 00000001 0
R 00400028 00000080 0
R 0040002c 000000fe 0
P 0 0
P 1 1
P 2 128
P 3 254
W 00400020 000000ff 0
R 00400020 000000ff 0
P 0 255
R 00400030 00000000 1
O a5 555 7f0

/* all.f */
hdl/rp_pkg.sv
hdl/rp_adc_frontend.sv
hdl/rp_sys_bus_decoder.sv
hdl/rp_hk.sv
hdl/rp_ams.sv
hdl/rp_pdm.sv
hdl/rp_top.sv
sim/tb_rp_top.sv

/* Makefile */
# Verilator build and run of the tb_rp_top testbench

VERILATOR  ?= verilator
TOP        ?= tb_rp_top
RTL_TOP    ?= rp_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard hdl/*.sv) $(wildcard sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, not the exit status of the pipe
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
